//--- verilog.f
verilog/axi_pkg.sv
verilog/link_pkg.sv
verilog/link_online_sync.sv
verilog/link_receive.sv
verilog/link_transmit.sv
verilog/phy_word_pack.sv
verilog/axi_link_slave_top.sv
sim/tb_axi_link_slave.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_axi_link_slave -f verilog.f -o tb_axi_link_slave_sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/tb_axi_link_slave_sim | tee /dev/stderr | grep "STATUS: PASS" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sim/tb_axi_link_slave.sv
// Single clock testbench; expects delay_y_value 5 and init_r_credit 3, and far side credits ignored

`timescale 1ns/1ns

module tb_axi_link_slave;

  import axi_pkg::*;
  import link_pkg::*;

  // About ten times the length of all tests together
  localparam int MAX_CYCLES = 2000;
  localparam int AR_COUNT   = 20;

  // Field offsets inside the PHY words
  localparam int AR_BURST_OFS = RX_AR_LSB + AXI_ADDR_W;
  localparam int AR_LEN_OFS   = AR_BURST_OFS + AXI_BURST_W;
  localparam int AR_SIZE_OFS  = AR_LEN_OFS + AXI_LEN_W;
  localparam int AR_ID_OFS    = AR_SIZE_OFS + AXI_SIZE_W;
  localparam int R_RESP_OFS   = TX_R_LSB + AXI_DATA_W;
  localparam int R_LAST_OFS   = R_RESP_OFS + AXI_RESP_W;
  localparam int R_ID_OFS     = R_LAST_OFS + 1;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   tx_online;
  logic                   rx_online;
  logic [CREDIT_W-1:0]    init_r_credit;
  logic [DELAY_W-1:0]     delay_x_value;
  logic [DELAY_W-1:0]     delay_y_value;
  logic [PHY_W-1:0]       rx_phy;
  logic [PHY_W-1:0]       tx_phy;
  logic [AXI_ID_W-1:0]    user_arid;
  logic [AXI_SIZE_W-1:0]  user_arsize;
  logic [AXI_LEN_W-1:0]   user_arlen;
  logic [AXI_BURST_W-1:0] user_arburst;
  logic [AXI_ADDR_W-1:0]  user_araddr;
  logic                   user_arvalid;
  logic                   user_arready;
  logic [AXI_ID_W-1:0]    user_rid;
  logic [AXI_DATA_W-1:0]  user_rdata;
  logic                   user_rlast;
  logic [AXI_RESP_W-1:0]  user_rresp;
  logic                   user_rvalid;
  logic                   user_rready;

  integer           seed = 32'h1c609ed9;
  int               check_cnt = 0;
  int               err_cnt = 0;
  int               cycle_cnt = 0;
  int               ar_sent = 0;
  int               ar_hs_cnt = 0;
  int               ar_credit_seen = 0;
  int               high_cnt = 0;
  int               accepted;
  logic             online_ref = 1'b0;
  logic             stb_exp = 1'b0;
  logic [PHY_W-1:0] ar_exp_q [$];
  logic [PHY_W-1:0] r_exp_q [$];

  axi_link_slave_top DUT (
    .clk_wr (clk), .rst_n (rst_n), .tx_online (tx_online), .rx_online (rx_online),
    .init_r_credit (init_r_credit), .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value), .rx_phy (rx_phy), .tx_phy (tx_phy),
    .user_arid (user_arid), .user_arsize (user_arsize), .user_arlen (user_arlen),
    .user_arburst (user_arburst), .user_araddr (user_araddr),
    .user_arvalid (user_arvalid), .user_arready (user_arready),
    .user_rid (user_rid), .user_rdata (user_rdata), .user_rlast (user_rlast),
    .user_rresp (user_rresp), .user_rvalid (user_rvalid), .user_rready (user_rready)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // Reference packing
  //////////////////////////////////////////////////
  function automatic logic [PHY_W-1:0] pack_ar_word(input logic [AXI_ID_W-1:0] id,
      input logic [AXI_SIZE_W-1:0] size, input logic [AXI_LEN_W-1:0] len,
      input logic [AXI_BURST_W-1:0] burst, input logic [AXI_ADDR_W-1:0] addr);
    logic [PHY_W-1:0] w;
    w = '0;
    w[RX_AR_PUSH_BIT] = 1'b1;
    w[RX_AR_LSB +: AXI_ADDR_W] = addr;
    w[AR_BURST_OFS +: AXI_BURST_W] = burst;
    w[AR_LEN_OFS +: AXI_LEN_W] = len;
    w[AR_SIZE_OFS +: AXI_SIZE_W] = size;
    w[AR_ID_OFS +: AXI_ID_W] = id;
    return w;
  endfunction

  // R words only leave while online, so the strobe is always set
  function automatic logic [PHY_W-1:0] pack_r_word(input logic [AXI_ID_W-1:0] id,
      input logic last, input logic [AXI_RESP_W-1:0] resp, input logic [AXI_DATA_W-1:0] data);
    logic [PHY_W-1:0] w;
    w = '0;
    w[TX_STB_BIT] = 1'b1;
    w[TX_R_PUSH_BIT] = 1'b1;
    w[TX_R_LSB +: AXI_DATA_W] = data;
    w[R_RESP_OFS +: AXI_RESP_W] = resp;
    w[R_LAST_OFS] = last;
    w[R_ID_OFS +: AXI_ID_W] = id;
    return w;
  endfunction

  task automatic check_value(input string name, input logic [PHY_W-1:0] got,
      input logic [PHY_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail: %s is 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d (%s) finished, %0d errors so far", num, name, err_cnt);
  endtask

  // Delayed online is high once more than delay_y_value edges have seen tx_online high
  always @(posedge clk) begin
    stb_exp = online_ref;
    if (tx_online) begin
      high_cnt++;
    end else begin
      high_cnt = 0;
    end
    online_ref = (high_cnt > int'(delay_y_value));
  end

  //////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////
  always @(negedge clk) begin : monitor
    logic [PHY_W-1:0] exp_w;
    logic [PHY_W-1:0] got_w;
    if (rst_n) begin
      check_value("tx_phy strobe", PHY_W'(tx_phy[TX_STB_BIT]), PHY_W'(stb_exp));
      if (tx_phy[TX_AR_CREDIT_BIT]) begin
        ar_credit_seen++;
      end
      got_w = tx_phy;
      got_w[TX_AR_CREDIT_BIT] = 1'b0;
      if (!tx_phy[TX_R_PUSH_BIT]) begin
        got_w[TX_STB_BIT] = 1'b0;
        check_value("tx_phy idle bits", got_w, '0);
      end else if (r_exp_q.size() == 0) begin
        err_cnt++;
        $display("Error: an R word left on tx_phy with no transfer accepted");
      end else begin
        exp_w = r_exp_q.pop_front();
        check_value("tx_phy", got_w, exp_w);
      end
      if (user_arvalid && user_arready) begin
        ar_hs_cnt++;
        if (ar_exp_q.size() == 0) begin
          err_cnt++;
          $display("Error: AR handshake without a request sent");
        end else begin
          exp_w = ar_exp_q.pop_front();
          check_value("user_araddr", PHY_W'(user_araddr), PHY_W'(exp_w[RX_AR_LSB +: AXI_ADDR_W]));
          check_value("user_arburst", PHY_W'(user_arburst),
                      PHY_W'(exp_w[AR_BURST_OFS +: AXI_BURST_W]));
          check_value("user_arlen", PHY_W'(user_arlen), PHY_W'(exp_w[AR_LEN_OFS +: AXI_LEN_W]));
          check_value("user_arsize", PHY_W'(user_arsize), PHY_W'(exp_w[AR_SIZE_OFS +: AXI_SIZE_W]));
          check_value("user_arid", PHY_W'(user_arid), PHY_W'(exp_w[AR_ID_OFS +: AXI_ID_W]));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////
  task automatic measure_rready_delay();
    int low_cycles;
    low_cycles = 0;
    @(posedge clk);
    #1;
    tx_online = 1'b1;
    rx_online = 1'b1;
    // First edge that samples tx_online high
    @(posedge clk);
    @(negedge clk);
    while (!user_rready && low_cycles < 100) begin
      low_cycles++;
      @(negedge clk);
    end
    check_value("user_rready low cycles", PHY_W'(low_cycles), PHY_W'(delay_y_value));
    repeat (4) @(negedge clk);
  endtask

  task automatic send_ar_requests();
    logic [31:0]      rnd_a;
    logic [31:0]      rnd_b;
    logic [PHY_W-1:0] w;
    while (ar_hs_cnt < AR_COUNT) begin
      @(posedge clk);
      #1;
      rnd_a = $random(seed);
      user_arready = rnd_a[0];
      if (ar_sent < AR_COUNT && ar_sent - ar_hs_cnt < AR_FIFO_DEPTH && rnd_a[1]) begin
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        w = pack_ar_word(rnd_b[0 +: AXI_ID_W], rnd_b[8 +: AXI_SIZE_W],
                         rnd_b[16 +: AXI_LEN_W], rnd_b[24 +: AXI_BURST_W], rnd_a);
        ar_exp_q.push_back(w);
        rx_phy = w;
        ar_sent++;
      end else begin
        rx_phy = '0;
      end
    end
    @(posedge clk);
    #1;
    user_arready = 1'b0;
    rx_phy = '0;
    check_value("AR requests left", PHY_W'(ar_exp_q.size()), '0);
  endtask

  task automatic new_r_beat();
    logic [31:0] rnd;
    user_rdata = {$random(seed), $random(seed)};
    rnd = $random(seed);
    user_rid = rnd[0 +: AXI_ID_W];
    user_rresp = rnd[8 +: AXI_RESP_W];
    user_rlast = rnd[16];
  endtask

  // Holds a beat valid until it is taken, for a fixed window of cycles
  task automatic offer_r_beats(input int cycles, output int accepted_beats);
    logic taken;
    accepted_beats = 0;
    @(posedge clk);
    #1;
    new_r_beat();
    user_rvalid = 1'b1;
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      taken = user_rready;
      if (taken) begin
        r_exp_q.push_back(pack_r_word(user_rid, user_rlast, user_rresp, user_rdata));
        accepted_beats++;
      end
      @(posedge clk);
      #1;
      if (taken) begin
        new_r_beat();
      end
    end
    user_rvalid = 1'b0;
    repeat (3) @(negedge clk);
    check_value("R words pending", PHY_W'(r_exp_q.size()), '0);
  endtask

  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_r_credit = 8'd3;
    delay_x_value = 16'd2;
    delay_y_value = 16'd5;
    rx_phy = '0;
    user_arready = 1'b0;
    user_rid = '0;
    user_rdata = '0;
    user_rlast = 1'b0;
    user_rresp = '0;
    user_rvalid = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    check_value("user_arvalid", PHY_W'(user_arvalid), '0);
    check_value("user_rready", PHY_W'(user_rready), '0);
    check_value("tx_phy", tx_phy, '0);
    report_test(1, "idle after reset");
    measure_rready_delay();
    report_test(2, "online delay and strobe");
    send_ar_requests();
    report_test(3, "AR requests in order");
    repeat (3) @(negedge clk);
    check_value("AR credit count", PHY_W'(ar_credit_seen), PHY_W'(ar_hs_cnt));
    report_test(4, "AR credit return");
    offer_r_beats(10, accepted);
    check_value("R transfers accepted", PHY_W'(accepted), PHY_W'(init_r_credit));
    check_value("user_rready", PHY_W'(user_rready), '0);
    report_test(5, "R transfers on initial credits");

    // One returned credit in a single receive word
    @(posedge clk);
    #1;
    rx_phy[RX_R_CREDIT_BIT] = 1'b1;
    @(posedge clk);
    #1;
    rx_phy = '0;
    offer_r_beats(10, accepted);
    check_value("R transfers accepted", PHY_W'(accepted), PHY_W'(1));
    report_test(6, "R transfer on returned credit");

    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/axi_link_slave_top.sv
// AXI read slave endpoint over one 80-bit PHY word; single clock, no write channels

`timescale 1ns/1ns

module axi_link_slave_top (
  input  logic                             clk_wr,
  input  logic                             rst_n,

  // Link control
  input  logic                             tx_online,
  input  logic                             rx_online,
  input  logic [link_pkg::CREDIT_W-1:0]    init_r_credit,
  input  logic [link_pkg::DELAY_W-1:0]     delay_x_value,
  input  logic [link_pkg::DELAY_W-1:0]     delay_y_value,

  // PHY
  input  logic [link_pkg::PHY_W-1:0]       rx_phy,
  output logic [link_pkg::PHY_W-1:0]       tx_phy,

  // AR channel
  output logic [axi_pkg::AXI_ID_W-1:0]     user_arid,
  output logic [axi_pkg::AXI_SIZE_W-1:0]   user_arsize,
  output logic [axi_pkg::AXI_LEN_W-1:0]    user_arlen,
  output logic [axi_pkg::AXI_BURST_W-1:0]  user_arburst,
  output logic [axi_pkg::AXI_ADDR_W-1:0]   user_araddr,
  output logic                             user_arvalid,
  input  logic                             user_arready,

  // R channel
  input  logic [axi_pkg::AXI_ID_W-1:0]     user_rid,
  input  logic [axi_pkg::AXI_DATA_W-1:0]   user_rdata,
  input  logic                             user_rlast,
  input  logic [axi_pkg::AXI_RESP_W-1:0]   user_rresp,
  input  logic                             user_rvalid,
  output logic                             user_rready
);

  import axi_pkg::*;

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////
  logic        tx_online_delay;
  logic        rx_online_delay;
  logic        ar_push;
  ar_payload_t rx_ar_payload;
  ar_payload_t fifo_ar_payload;
  logic        ar_credit;
  r_payload_t  user_r_payload;
  r_payload_t  tx_r_payload;
  logic        r_push;
  logic        r_credit;

  //////////////////////////////////////////////////
  // AXI field mapping
  //////////////////////////////////////////////////
  assign user_arid    = fifo_ar_payload.id;
  assign user_arsize  = fifo_ar_payload.size;
  assign user_arlen   = fifo_ar_payload.len;
  assign user_arburst = fifo_ar_payload.burst;
  assign user_araddr  = fifo_ar_payload.addr;

  assign user_r_payload.id   = user_rid;
  assign user_r_payload.last = user_rlast;
  assign user_r_payload.resp = user_rresp;
  assign user_r_payload.data = user_rdata;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////
  link_online_sync u_online_sync (
    // Outputs
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    // Inputs
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value)
  );

  link_receive u_receive_ar (
    // Outputs
    .fifo_ar_payload (fifo_ar_payload),
    .user_arvalid    (user_arvalid),
    .ar_credit       (ar_credit),
    // Inputs
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .ar_push         (ar_push),
    .ar_payload      (rx_ar_payload),
    .user_arready    (user_arready)
  );

  link_transmit u_transmit_r (
    // Outputs
    .user_rready     (user_rready),
    .r_push          (r_push),
    .r_payload_out   (tx_r_payload),
    // Inputs
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .init_r_credit   (init_r_credit),
    .user_rvalid     (user_rvalid),
    .r_payload_in    (user_r_payload),
    .r_credit        (r_credit)
  );

  phy_word_pack u_phy_word_pack (
    // Outputs
    .tx_phy          (tx_phy),
    .ar_push         (ar_push),
    .ar_payload      (rx_ar_payload),
    .r_credit        (r_credit),
    // Inputs
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .rx_phy          (rx_phy),
    .rx_online_delay (rx_online_delay),
    .tx_online_delay (tx_online_delay),
    .r_push          (r_push),
    .r_payload       (tx_r_payload),
    .ar_credit       (ar_credit)
  );

endmodule

//--- verilog/phy_word_pack.sv
// One PHY word per direction per clock; receive fields are ignored until rx_online_delay is high

`timescale 1ns/1ns

module phy_word_pack (
  input  logic                       clk_wr,
  input  logic                       rst_n,
  input  logic [link_pkg::PHY_W-1:0] rx_phy,
  input  logic                       rx_online_delay,
  input  logic                       tx_online_delay,
  input  logic                       r_push,
  input  axi_pkg::r_payload_t        r_payload,
  input  logic                       ar_credit,
  output logic [link_pkg::PHY_W-1:0] tx_phy,
  output logic                       ar_push,
  output axi_pkg::ar_payload_t       ar_payload,
  output logic                       r_credit
);

  import axi_pkg::*;
  import link_pkg::*;

  logic [PHY_W-1:0] rx_phy_q;
  logic [PHY_W-1:0] tx_word;

  //////////////////////////////////////////////////
  // Receive word
  //////////////////////////////////////////////////
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_phy_q <= '0;
    end else begin
      rx_phy_q <= rx_phy;
    end
  end

  // Push and credit bits only count once the receive side is online
  assign ar_push    = rx_online_delay && rx_phy_q[RX_AR_PUSH_BIT];
  assign r_credit   = rx_online_delay && rx_phy_q[RX_R_CREDIT_BIT];
  assign ar_payload = ar_payload_t'(rx_phy_q[RX_AR_LSB +: $bits(ar_payload_t)]);

  //////////////////////////////////////////////////
  // Transmit word
  //////////////////////////////////////////////////
  always_comb begin
    tx_word                = '0;
    tx_word[TX_STB_BIT]    = tx_online_delay;
    tx_word[TX_R_PUSH_BIT] = r_push;
    // Payload field left at zero on idle words
    if (r_push) begin
      tx_word[TX_R_LSB +: $bits(r_payload_t)] = r_payload;
    end
    tx_word[TX_AR_CREDIT_BIT] = ar_credit;
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_word;
    end
  end

endmodule

//--- verilog/link_transmit.sv
// Credit count follows init_r_credit while offline; no overflow check on returned credits

`timescale 1ns/1ns

module link_transmit (
  input  logic                          clk_wr,
  input  logic                          rst_n,
  input  logic                          tx_online_delay,
  input  logic [link_pkg::CREDIT_W-1:0] init_r_credit,
  input  logic                          user_rvalid,
  input  axi_pkg::r_payload_t           r_payload_in,
  input  logic                          r_credit,
  output logic                          user_rready,
  output logic                          r_push,
  output axi_pkg::r_payload_t           r_payload_out
);

  import link_pkg::*;

  logic [CREDIT_W-1:0] credit_cnt;
  logic                r_hs;

  // Accept only with the link up and a buffer free on the far side
  assign user_rready = tx_online_delay && (credit_cnt != '0);
  assign r_hs        = user_rvalid && user_rready;

  //////////////////////////////////////////////////
  // Credit counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= '0;
    end else if (!tx_online_delay) begin
      credit_cnt <= init_r_credit;
    end else begin
      case ({r_hs, r_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      r_push <= 1'b0;
    end else begin
      r_push <= r_hs;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (r_hs) begin
      r_payload_out <= r_payload_in;
    end
  end

endmodule

//--- verilog/link_receive.sv
// Far side must respect the credits it holds; a push into a full FIFO is dropped

`timescale 1ns/1ns

module link_receive (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  logic                 ar_push,
  input  axi_pkg::ar_payload_t ar_payload,
  input  logic                 user_arready,
  output axi_pkg::ar_payload_t fifo_ar_payload,
  output logic                 user_arvalid,
  output logic                 ar_credit
);

  import axi_pkg::*;
  import link_pkg::*;

  ar_payload_t         fifo_mem [AR_FIFO_DEPTH];
  logic [AR_PTR_W-1:0] wr_ptr;
  logic [AR_PTR_W-1:0] rd_ptr;
  logic [AR_PTR_W:0]   fifo_cnt;
  logic                fifo_full;
  logic                push;
  logic                pop;

  assign fifo_full    = (fifo_cnt == (AR_PTR_W + 1)'(AR_FIFO_DEPTH));
  assign user_arvalid = (fifo_cnt != '0);
  assign push         = ar_push && !fifo_full;
  assign pop          = user_arvalid && user_arready;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk_wr) begin
    if (push) begin
      fifo_mem[wr_ptr] <= ar_payload;
    end
  end

  // Head of queue stays on the AR port until it is taken
  assign fifo_ar_payload = fifo_mem[rd_ptr];

  //////////////////////////////////////////////////
  // Pointers, occupancy and credit return
  //////////////////////////////////////////////////
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fifo_cnt  <= '0;
      ar_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
      // One credit back per entry freed
      ar_credit <= pop;
    end
  end

endmodule

//--- verilog/link_online_sync.sv
// Delay counts are taken while the online input is low; a delay of zero passes online through

`timescale 1ns/1ns

module link_online_sync (
  input  logic                         clk_wr,
  input  logic                         rst_n,
  input  logic                         tx_online,
  input  logic                         rx_online,
  input  logic [link_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [link_pkg::DELAY_W-1:0] delay_y_value,
  output logic                         tx_online_delay,
  output logic                         rx_online_delay
);

  import link_pkg::*;

  // Index 0 is the receive side (x), index 1 the transmit side (y)
  logic [1:0]         online_in;
  logic [DELAY_W-1:0] delay_val [2];
  logic [DELAY_W-1:0] delay_cnt [2];
  logic [1:0]         online_q;

  assign online_in    = {tx_online, rx_online};
  assign delay_val[0] = delay_x_value;
  assign delay_val[1] = delay_y_value;

  //////////////////////////////////////////////////
  // Down-counters and delayed online flags
  //////////////////////////////////////////////////
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      online_q <= '0;
      for (int i = 0; i < 2; i++) begin
        delay_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          // Reload while offline, drop the flag at once
          delay_cnt[i] <= delay_val[i];
          online_q[i]  <= 1'b0;
        end else if (delay_cnt[i] != '0) begin
          delay_cnt[i] <= delay_cnt[i] - 1'b1;
        end else begin
          online_q[i] <= 1'b1;
        end
      end
    end
  end

  assign rx_online_delay = online_q[0];
  assign tx_online_delay = online_q[1];

endmodule

//--- verilog/link_pkg.sv
// Single 80-bit PHY word per direction; AR_FIFO_DEPTH must be a power of two

package link_pkg;

  //////////////////////////////////////////////////
  // PHY word
  //////////////////////////////////////////////////
  localparam int PHY_W = 80;

  // Receive word, AR payload sits in bits 1 to 49
  localparam int RX_AR_PUSH_BIT  = 0;
  localparam int RX_AR_LSB       = 1;
  localparam int RX_R_CREDIT_BIT = 50;

  // Transmit word, R payload sits in bits 2 to 72
  localparam int TX_STB_BIT       = 0;
  localparam int TX_R_PUSH_BIT    = 1;
  localparam int TX_R_LSB         = 2;
  localparam int TX_AR_CREDIT_BIT = 73;

  // Bits not listed above stay zero

  //////////////////////////////////////////////////
  // Buffering and counters
  //////////////////////////////////////////////////

  // AR receive FIFO, sized to the credits granted to the far side
  localparam int AR_FIFO_DEPTH = 8;
  localparam int AR_PTR_W      = $clog2(AR_FIFO_DEPTH);

  // Transmit credit counter
  localparam int CREDIT_W = 8;

  // Online delay counters
  localparam int DELAY_W = 16;

endpackage

//--- verilog/axi_pkg.sv
// AXI read channel widths and payload layouts; write channels are not carried over the link

package axi_pkg;

  //////////////////////////////////////////////////
  // AXI field widths
  //////////////////////////////////////////////////
  localparam int AXI_ID_W    = 4;
  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_DATA_W  = 64;
  localparam int AXI_LEN_W   = 8;
  localparam int AXI_SIZE_W  = 3;
  localparam int AXI_BURST_W = 2;
  localparam int AXI_RESP_W  = 2;

  //////////////////////////////////////////////////
  // Channel payloads, first member is the MSB
  //////////////////////////////////////////////////

  // AR request, 49 bits, addr in the low bits
  typedef struct packed {
    logic [AXI_ID_W-1:0]    id;
    logic [AXI_SIZE_W-1:0]  size;
    logic [AXI_LEN_W-1:0]   len;
    logic [AXI_BURST_W-1:0] burst;
    logic [AXI_ADDR_W-1:0]  addr;
  } ar_payload_t;

  // R beat, 71 bits, data in the low bits
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic                  last;
    logic [AXI_RESP_W-1:0] resp;
    logic [AXI_DATA_W-1:0] data;
  } r_payload_t;

endpackage
